// File: verilog/rv_pkg.sv
package rv_pkg;

    // Major opcodes, instruction bits 6 to 2.
    localparam logic [4:0] opc_op = 5'b01100;
    localparam logic [4:0] opc_lui = 5'b01101;
    localparam logic [4:0] opc_auipc = 5'b00101;
    localparam logic [4:0] opc_jal = 5'b11011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_sr = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // The alternate funct7 turns ADD into SUB and SRL into SRA.
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef enum logic [1:0] {
        none,
        illegal,
        misaligned,
        decode
    } exc_cause_t;

endpackage

// File: verilog/exec_if.sv
`timescale 1ns/10ps

interface exec_op_if #(
    parameter int xlen = 32,
    parameter int alen = 32
);
    logic valid;
    logic is_jump;
    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [31:12] u_imm;
    logic [20:1] j_imm;
    logic [alen-1:0] instruction_addr;
    logic [alen-1:0] instruction_next_addr;

    modport stage (
        output valid, is_jump, opcode, funct3, funct7, rs1_val, rs2_val,
        output u_imm, j_imm, instruction_addr, instruction_next_addr
    );

    modport unit (
        input valid, is_jump, opcode, funct3, funct7, rs1_val, rs2_val,
        input u_imm, j_imm, instruction_addr, instruction_next_addr
    );
endinterface

interface exec_res_if #(
    parameter int xlen = 32,
    parameter int alen = 32
);
    logic out_valid;
    logic exception;
    rv_pkg::exc_cause_t cause;
    logic [xlen-1:0] result;
    logic [alen-1:0] target;

    modport unit (output out_valid, exception, cause, result, target);
    modport stage (input out_valid, exception, cause, result, target);
endinterface

// File: verilog/exec_int.sv
`timescale 1ns/10ps

module exec_int #(
    parameter int xlen = 32,
    parameter int alen = 32
) (
    input logic clk,
    input logic rst,
    exec_op_if.unit op,
    exec_res_if.unit res
);

    localparam int shw = $clog2(xlen);

    logic take;
    logic alt;
    logic illegal_op;
    logic [shw-1:0] shamt;
    logic [xlen-1:0] upper;
    logic [alen-1:0] pc_rel;
    logic [xlen-1:0] alu;

    // Every non-jump instruction lands here, so unknown opcodes still produce a result.
    assign take = op.valid && !op.is_jump;
    assign alt = op.funct7 == rv_pkg::f7_alt;
    assign shamt = op.rs2_val[shw-1:0];
    assign upper = xlen'($signed({op.u_imm, 12'h000}));
    assign pc_rel = op.instruction_addr + alen'($signed({op.u_imm, 12'h000}));

    always_comb begin
        alu = '0;
        illegal_op = 1'b0;
        case (op.opcode)
            rv_pkg::opc_lui: alu = upper;
            rv_pkg::opc_auipc: alu = xlen'(pc_rel);
            rv_pkg::opc_op: begin
                if (op.funct7 != rv_pkg::f7_base && !alt) begin
                    illegal_op = 1'b1;
                end
                // Only SUB and SRA have an alternate encoding.
                if (alt && op.funct3 != rv_pkg::f3_add && op.funct3 != rv_pkg::f3_sr) begin
                    illegal_op = 1'b1;
                end
                case (op.funct3)
                    rv_pkg::f3_add: alu = alt ? op.rs1_val - op.rs2_val
                                              : op.rs1_val + op.rs2_val;
                    rv_pkg::f3_sll: alu = op.rs1_val << shamt;
                    rv_pkg::f3_slt: alu = xlen'($signed(op.rs1_val) < $signed(op.rs2_val));
                    rv_pkg::f3_sltu: alu = xlen'(op.rs1_val < op.rs2_val);
                    rv_pkg::f3_xor: alu = op.rs1_val ^ op.rs2_val;
                    rv_pkg::f3_sr: alu = alt ? $unsigned($signed(op.rs1_val) >>> shamt)
                                             : op.rs1_val >> shamt;
                    rv_pkg::f3_or: alu = op.rs1_val | op.rs2_val;
                    default: alu = op.rs1_val & op.rs2_val;
                endcase
            end
            default: illegal_op = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.out_valid <= 1'b0;
        end else begin
            res.out_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res.result <= alu;
            res.exception <= illegal_op;
            res.cause <= illegal_op ? rv_pkg::illegal : rv_pkg::none;
        end
    end

    // This unit never redirects the PC.
    assign res.target = '0;

endmodule

// File: verilog/exec_branch.sv
`timescale 1ns/10ps

module exec_branch #(
    parameter int xlen = 32,
    parameter int alen = 32,
    parameter bit has_c = 1'b0
) (
    input logic clk,
    input logic rst,
    exec_op_if.unit op,
    exec_res_if.unit res,
    output logic mispredict
);

    logic take;
    logic bad_op;
    logic bad_align;
    logic [alen-1:0] jump_target;

    assign take = op.valid && op.is_jump;
    assign bad_op = op.opcode != rv_pkg::opc_jal;
    assign jump_target = op.instruction_addr + alen'($signed({op.j_imm, 1'b0}));

    // Without compressed instructions every target must be word aligned.
    assign bad_align = !has_c && jump_target[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            res.out_valid <= 1'b0;
        end else begin
            res.out_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res.result <= xlen'(op.instruction_next_addr);
            res.target <= jump_target;
            res.exception <= bad_op || bad_align;
            if (bad_op) begin
                res.cause <= rv_pkg::illegal;
            end else if (bad_align) begin
                res.cause <= rv_pkg::misaligned;
            end else begin
                res.cause <= rv_pkg::none;
            end
        end
    end

    // Decode always predicts fall-through, so a taken jump is always a mispredict.
    assign mispredict = res.out_valid && !res.exception;

endmodule

// File: verilog/exec.sv
`timescale 1ns/10ps

module exec #(
    parameter int xlen = 32,
    parameter int alen = 32,
    parameter bit has_c = 1'b0
) (
    input logic clk,
    input logic rst,
    input logic prev_stalled,
    output logic stall_prev,
    output logic stall_next,
    input logic decode_exception,
    input logic decode_is_jump,
    input logic decode_is_reg_write,
    input logic [alen-1:0] decode_instruction_addr,
    input logic [alen-1:0] decode_instruction_next_addr,
    input logic [4:0] opcode,
    input logic [4:0] rd,
    input logic [2:0] funct3,
    input logic [6:0] funct7,
    input logic [31:12] u_imm,
    input logic [20:1] j_imm,
    input logic [xlen-1:0] rs1_val,
    input logic [xlen-1:0] rs2_val,
    output logic exec_exception,
    output rv_pkg::exc_cause_t exec_cause,
    output logic exec_is_branch,
    output logic exec_is_reg_write,
    output logic [4:0] exec_reg_write_sel,
    output logic [xlen-1:0] exec_result,
    output logic [alen-1:0] exec_branch_target,
    output logic [alen-1:0] exec_instruction_next_addr,
    output logic exec_pipeline_flush
);

    logic busy;
    logic stopped;
    logic accept;
    logic input_valid;

    exec_op_if #(.xlen(xlen), .alen(alen)) op ();
    exec_res_if #(.xlen(xlen), .alen(alen)) int_res ();
    exec_res_if #(.xlen(xlen), .alen(alen)) br_res ();

    assign accept = !prev_stalled && !stall_prev;
    // The instruction seen during a flush is the wrong-path one and is consumed unexecuted.
    assign input_valid = accept && !decode_exception && !exec_pipeline_flush;

    assign op.valid = input_valid;
    assign op.is_jump = decode_is_jump;
    assign op.opcode = opcode;
    assign op.funct3 = funct3;
    assign op.funct7 = funct7;
    assign op.rs1_val = rs1_val;
    assign op.rs2_val = rs2_val;
    assign op.u_imm = u_imm;
    assign op.j_imm = j_imm;
    assign op.instruction_addr = decode_instruction_addr;
    assign op.instruction_next_addr = decode_instruction_next_addr;

    exec_int #(.xlen(xlen), .alen(alen)) exec_int_i (
        .clk(clk),
        .rst(rst),
        .op(op.unit),
        .res(int_res.unit)
    );

    exec_branch #(.xlen(xlen), .alen(alen), .has_c(has_c)) exec_branch_i (
        .clk(clk),
        .rst(rst),
        .op(op.unit),
        .res(br_res.unit),
        .mispredict(exec_pipeline_flush)
    );

    assign exec_is_branch = br_res.out_valid;
    assign exec_branch_target = br_res.target;
    assign stall_prev = stopped || (busy && stall_next);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            stopped <= 1'b0;
            exec_is_reg_write <= 1'b0;
        end else begin
            busy <= input_valid;
            exec_is_reg_write <= input_valid && decode_is_reg_write;
            if (accept && decode_exception && !exec_pipeline_flush) begin
                stopped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (input_valid) begin
            exec_reg_write_sel <= rd;
            exec_instruction_next_addr <= decode_instruction_next_addr;
        end
    end

    always_comb begin
        unique case (1'b1)
            br_res.out_valid: begin
                stall_next = 1'b0;
                exec_exception = br_res.exception;
                exec_cause = br_res.cause;
                exec_result = br_res.result;
            end
            int_res.out_valid: begin
                stall_next = 1'b0;
                exec_exception = int_res.exception;
                exec_cause = int_res.cause;
                exec_result = int_res.result;
            end
            default: begin
                exec_exception = stopped;
                exec_cause = stopped ? rv_pkg::decode : rv_pkg::none;
                stall_next = !stopped;
                exec_result = '0;
            end
        endcase
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file #(
    parameter int xlen = 32
) (
    input logic clk,
    input logic rst,
    input logic [4:0] rs1,
    input logic [4:0] rs2,
    output logic [xlen-1:0] rs1_val,
    output logic [xlen-1:0] rs2_val,
    input logic wr_en,
    input logic wr_exception,
    input logic [4:0] wr_sel,
    input logic [xlen-1:0] wr_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && !wr_exception && wr_sel != 5'd0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // x0 reads as zero.
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: verilog/exec_top.sv
`timescale 1ns/10ps

module exec_top #(
    parameter int xlen = 32,
    parameter int alen = 32,
    parameter bit has_c = 1'b0
) (
    input logic clk,
    input logic rst,
    input logic prev_stalled,
    output logic stall_prev,
    output logic stall_next,
    input logic decode_exception,
    input logic decode_is_jump,
    input logic decode_is_reg_write,
    input logic [alen-1:0] decode_instruction_addr,
    input logic [alen-1:0] decode_instruction_next_addr,
    input logic [4:0] opcode,
    input logic [4:0] rd,
    input logic [2:0] funct3,
    input logic [4:0] rs1,
    input logic [4:0] rs2,
    input logic [6:0] funct7,
    input logic [31:12] u_imm,
    input logic [20:1] j_imm,
    output logic exec_exception,
    output rv_pkg::exc_cause_t exec_cause,
    output logic exec_is_branch,
    output logic exec_is_reg_write,
    output logic [4:0] exec_reg_write_sel,
    output logic [xlen-1:0] exec_result,
    output logic [alen-1:0] exec_branch_target,
    output logic [alen-1:0] exec_instruction_next_addr,
    output logic exec_pipeline_flush
);

    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    exec #(.xlen(xlen), .alen(alen), .has_c(has_c)) exec_i (
        .clk(clk),
        .rst(rst),
        .prev_stalled(prev_stalled),
        .stall_prev(stall_prev),
        .stall_next(stall_next),
        .decode_exception(decode_exception),
        .decode_is_jump(decode_is_jump),
        .decode_is_reg_write(decode_is_reg_write),
        .decode_instruction_addr(decode_instruction_addr),
        .decode_instruction_next_addr(decode_instruction_next_addr),
        .opcode(opcode),
        .rd(rd),
        .funct3(funct3),
        .funct7(funct7),
        .u_imm(u_imm),
        .j_imm(j_imm),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .exec_exception(exec_exception),
        .exec_cause(exec_cause),
        .exec_is_branch(exec_is_branch),
        .exec_is_reg_write(exec_is_reg_write),
        .exec_reg_write_sel(exec_reg_write_sel),
        .exec_result(exec_result),
        .exec_branch_target(exec_branch_target),
        .exec_instruction_next_addr(exec_instruction_next_addr),
        .exec_pipeline_flush(exec_pipeline_flush)
    );

    reg_file #(.xlen(xlen)) reg_file_i (
        .clk(clk),
        .rst(rst),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .wr_en(exec_is_reg_write),
        .wr_exception(exec_exception),
        .wr_sel(exec_reg_write_sel),
        .wr_data(exec_result)
    );

endmodule

// File: bench/exec_props.sv
`timescale 1ns/10ps

module exec_props (
    input logic clk,
    input logic rst,
    input logic int_valid,
    input logic br_valid,
    input logic flush,
    input logic is_branch,
    input logic stopped,
    input logic exception
);

    // The two units never finish in the same cycle.
    one_result: assert property (@(posedge clk) disable iff (rst) !(int_valid && br_valid))
        else $error("both units raised out_valid in one cycle");

    flush_is_branch: assert property (@(posedge clk) disable iff (rst) flush |-> is_branch)
        else $error("pipeline flush without a branch result");

    stop_raises: assert property (@(posedge clk) disable iff (rst) stopped |-> exception)
        else $error("stage stopped but exec_exception is low");

endmodule

bind exec exec_props exec_props_i (
    .clk(clk),
    .rst(rst),
    .int_valid(int_res.out_valid),
    .br_valid(br_res.out_valid),
    .flush(exec_pipeline_flush),
    .is_branch(exec_is_branch),
    .stopped(stopped),
    .exception(exec_exception)
);

// File: bench/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;

    typedef struct {
        string name;
        logic [4:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [19:0] imm;
        logic [31:0] addr;
        logic is_jump;
        logic dec_exc;
        logic shadow;
        rv_pkg::exc_cause_t cause;
    } test_t;

    logic clk;
    logic rst;
    logic prev_stalled;
    logic stall_prev;
    logic stall_next;
    logic decode_exception;
    logic decode_is_jump;
    logic decode_is_reg_write;
    logic [31:0] decode_instruction_addr;
    logic [31:0] decode_instruction_next_addr;
    logic [4:0] opcode;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [6:0] funct7;
    logic [31:12] u_imm;
    logic [20:1] j_imm;
    logic exec_exception;
    rv_pkg::exc_cause_t exec_cause;
    logic exec_is_branch;
    logic exec_is_reg_write;
    logic [4:0] exec_reg_write_sel;
    logic [31:0] exec_result;
    logic [31:0] exec_branch_target;
    logic [31:0] exec_instruction_next_addr;
    logic exec_pipeline_flush;

    test_t tests[$];
    test_t shadow_op;
    logic [31:0] model_regs [32];
    logic [31:0] lfsr = 32'h47f9;
    logic [31:0] pc = 32'h0000_1000;
    logic stopped_model = 1'b0;
    int errors = 0;

    exec_top exec_top_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic test_t blank(input string name);
        test_t t;
        t = '{name: name, addr: pc, cause: rv_pkg::none, default: '0};
        pc = pc + 32'd4;
        return t;
    endfunction

    task automatic add_r(input string name, input logic [2:0] f3, input logic [6:0] f7,
                         input logic [4:0] d, input logic [4:0] s1, input logic [4:0] s2,
                         input rv_pkg::exc_cause_t cause);
        test_t t;
        t = blank(name);
        t.opcode = rv_pkg::opc_op;
        t.funct3 = f3;
        t.funct7 = f7;
        t.rd = d;
        t.rs1 = s1;
        t.rs2 = s2;
        t.cause = cause;
        tests.push_back(t);
    endtask

    task automatic add_other(input string name, input logic [4:0] opc, input logic [4:0] d,
                             input logic [19:0] imm, input logic [31:0] addr,
                             input logic shadow, input rv_pkg::exc_cause_t cause);
        test_t t;
        t = blank(name);
        t.opcode = opc;
        t.rd = d;
        t.imm = imm;
        t.addr = addr;
        t.is_jump = opc == rv_pkg::opc_jal;
        t.shadow = shadow;
        t.cause = cause;
        t.dec_exc = cause == rv_pkg::decode;
        tests.push_back(t);
    endtask

    // Reference model built from the RV32I instruction definitions.
    function automatic logic [31:0] model_result(input test_t t);
        logic [31:0] a;
        logic [31:0] b;
        logic signed [31:0] sa;
        a = model_regs[t.rs1];
        b = model_regs[t.rs2];
        sa = a;
        if (t.opcode == rv_pkg::opc_lui) begin
            return {t.imm, 12'h000};
        end else if (t.opcode == rv_pkg::opc_auipc) begin
            return t.addr + {t.imm, 12'h000};
        end else if (t.opcode == rv_pkg::opc_jal) begin
            return t.addr + 32'd4;
        end
        case (t.funct3)
            rv_pkg::f3_add: return (t.funct7 == rv_pkg::f7_alt) ? a - b : a + b;
            rv_pkg::f3_sll: return a << b[4:0];
            rv_pkg::f3_slt: return {31'd0, $signed(a) < $signed(b)};
            rv_pkg::f3_sltu: return {31'd0, a < b};
            rv_pkg::f3_xor: return a ^ b;
            rv_pkg::f3_or: return a | b;
            rv_pkg::f3_and: return a & b;
            default: begin
                if (t.funct7 == rv_pkg::f7_alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
        endcase
    endfunction

    task automatic drive(input test_t t);
        opcode <= t.opcode;
        funct3 <= t.funct3;
        funct7 <= t.funct7;
        rd <= t.rd;
        rs1 <= t.rs1;
        rs2 <= t.rs2;
        u_imm <= t.imm;
        j_imm <= t.imm;
        decode_instruction_addr <= t.addr;
        decode_instruction_next_addr <= t.addr + 32'd4;
        decode_is_jump <= t.is_jump;
        decode_is_reg_write <= !t.dec_exc;
        decode_exception <= t.dec_exc;
        prev_stalled <= 1'b0;
    endtask

    task automatic check_value(input string name, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic run_test(input test_t t);
        logic [31:0] exp;
        logic [31:0] tgt;
        int errors_before;
        int n;
        errors_before = errors;
        exp = model_result(t);
        tgt = t.addr + {{11{t.imm[19]}}, t.imm, 1'b0};
        @(posedge clk);
        drive(t);
        @(posedge clk);
        if (t.shadow) begin
            drive(shadow_op);
        end else begin
            prev_stalled <= 1'b1;
        end
        if (stopped_model) begin
            // A stopped stage takes nothing in and holds its decode exception.
            repeat (3) begin
                @(negedge clk);
                check_value(t.name, "stall_prev", 1, stall_prev);
                check_value(t.name, "exec_is_reg_write", 0, exec_is_reg_write);
                check_value(t.name, "exec_is_branch", 0, exec_is_branch);
                check_value(t.name, "exec_exception", 1, exec_exception);
                check_value(t.name, "exec_cause", rv_pkg::decode, 32'(exec_cause));
            end
        end else begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (stall_next && !exec_exception && n < 10);
            if (stall_next && !exec_exception) begin
                $display("Test %s got no result from the stage within 10 cycles", t.name);
                errors++;
            end else begin
                check_value(t.name, "stall_next", 0, stall_next);
                check_value(t.name, "exec_exception", t.cause != rv_pkg::none, exec_exception);
                check_value(t.name, "exec_cause", 32'(t.cause), 32'(exec_cause));
                check_value(t.name, "exec_is_branch", t.is_jump, exec_is_branch);
                check_value(t.name, "exec_pipeline_flush", t.is_jump && t.cause == rv_pkg::none,
                            exec_pipeline_flush);
                check_value(t.name, "exec_is_reg_write", !t.dec_exc, exec_is_reg_write);
                if (!t.dec_exc) begin
                    check_value(t.name, "exec_instruction_next_addr", t.addr + 32'd4,
                                exec_instruction_next_addr);
                end
                if (t.cause == rv_pkg::none) begin
                    check_value(t.name, "exec_result", exp, exec_result);
                    check_value(t.name, "exec_reg_write_sel", t.rd, exec_reg_write_sel);
                end
                if (t.is_jump) begin
                    check_value(t.name, "exec_branch_target", tgt, exec_branch_target);
                end
            end
            if (t.shadow) begin
                @(posedge clk);
                prev_stalled <= 1'b1;
                @(negedge clk);
                if (!stall_next || exec_is_reg_write) begin
                    $display("Test %s: the instruction behind the jump was executed", t.name);
                    errors++;
                end
            end
        end
        if (t.cause == rv_pkg::none && !stopped_model && t.rd != 5'd0) begin
            model_regs[t.rd] = exp;
        end
        stopped_model = stopped_model || t.dec_exc;
        $display("%s %s", (errors == errors_before) ? "ok    " : "failed", t.name);
    endtask

    initial begin
        rst = 1'b1;
        prev_stalled = 1'b1;
        decode_exception = 1'b0;
        decode_is_jump = 1'b0;
        decode_is_reg_write = 1'b0;
        decode_instruction_addr = '0;
        decode_instruction_next_addr = '0;
        opcode = '0;
        rd = '0;
        funct3 = '0;
        rs1 = '0;
        rs2 = '0;
        funct7 = '0;
        u_imm = '0;
        j_imm = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        shadow_op = blank("shadow");
        shadow_op.opcode = rv_pkg::opc_op;
        shadow_op.rd = 5'd17;
        shadow_op.rs1 = 5'd2;
        shadow_op.rs2 = 5'd3;
        add_other("lui_x1", rv_pkg::opc_lui, 1, rand_bits(20), pc, 0, rv_pkg::none);
        add_other("auipc_x2", rv_pkg::opc_auipc, 2, rand_bits(20), rand_bits(32), 0, rv_pkg::none);
        add_other("auipc_x3", rv_pkg::opc_auipc, 3, rand_bits(20), rand_bits(32), 0, rv_pkg::none);
        add_other("auipc_x4", rv_pkg::opc_auipc, 4, rand_bits(20), rand_bits(32), 0, rv_pkg::none);
        add_r("add", rv_pkg::f3_add, rv_pkg::f7_base, 5, 2, 3, rv_pkg::none);
        add_r("sub", rv_pkg::f3_add, rv_pkg::f7_alt, 6, 2, 3, rv_pkg::none);
        add_r("sll", rv_pkg::f3_sll, rv_pkg::f7_base, 7, 2, 3, rv_pkg::none);
        add_r("slt", rv_pkg::f3_slt, rv_pkg::f7_base, 8, 2, 4, rv_pkg::none);
        add_r("sltu", rv_pkg::f3_sltu, rv_pkg::f7_base, 9, 3, 4, rv_pkg::none);
        add_r("xor", rv_pkg::f3_xor, rv_pkg::f7_base, 10, 2, 4, rv_pkg::none);
        add_r("srl", rv_pkg::f3_sr, rv_pkg::f7_base, 11, 2, 3, rv_pkg::none);
        add_r("sra", rv_pkg::f3_sr, rv_pkg::f7_alt, 12, 3, 4, rv_pkg::none);
        add_r("or", rv_pkg::f3_or, rv_pkg::f7_base, 13, 3, 4, rv_pkg::none);
        add_r("and", rv_pkg::f3_and, rv_pkg::f7_base, 14, 2, 4, rv_pkg::none);
        add_r("add_to_x0", rv_pkg::f3_add, rv_pkg::f7_base, 0, 2, 3, rv_pkg::none);
        add_r("read_x0_x1", rv_pkg::f3_or, rv_pkg::f7_base, 15, 0, 1, rv_pkg::none);
        add_other("jal", rv_pkg::opc_jal, 16, rand_bits(20) & 20'hffffe, pc, 1, rv_pkg::none);
        add_r("read_shadow_rd", rv_pkg::f3_or, rv_pkg::f7_base, 18, 17, 0, rv_pkg::none);
        add_r("read_link", rv_pkg::f3_add, rv_pkg::f7_base, 22, 16, 0, rv_pkg::none);
        add_r("bad_funct7", rv_pkg::f3_add, 7'h01, 5, 2, 2, rv_pkg::illegal);
        add_r("bad_alt_xor", rv_pkg::f3_xor, rv_pkg::f7_alt, 5, 2, 2, rv_pkg::illegal);
        add_r("read_x5", rv_pkg::f3_or, rv_pkg::f7_base, 19, 5, 0, rv_pkg::none);
        add_other("jal_misaligned", rv_pkg::opc_jal, 20, rand_bits(20) | 20'h1, pc, 0,
                  rv_pkg::misaligned);
        add_r("read_x20", rv_pkg::f3_or, rv_pkg::f7_base, 21, 20, 0, rv_pkg::none);
        add_other("decode_exception", rv_pkg::opc_op, 23, 0, pc, 0, rv_pkg::decode);
        add_r("after_stop", rv_pkg::f3_add, rv_pkg::f7_base, 24, 2, 3, rv_pkg::none);

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        foreach (tests[i]) begin
            run_test(tests[i]);
        end

        $display("%0d tests run, %0d errors", tests.size(), errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: rv_exec.f
verilog/rv_pkg.sv
verilog/exec_if.sv
verilog/exec_int.sv
verilog/exec_branch.sv
verilog/exec.sv
verilog/reg_file.sv
verilog/exec_top.sv
bench/exec_props.sv
bench/exec_tb.sv
